/* tests/alu_core_golden.txt */
# T <test name> | I <instr hex> <illegal 0/1> <rd decimal> <result hex>
# D <register decimal> <expected value hex> read through the debug port
T reset_state
D 0 00000000
D 1 00000000
D 7 00000000
D 16 00000000
D 31 00000000
T imm_ops
I FFB00093 0 1 FFFFFFFB
I 80008113 0 2 FFFFF7FB
I FFC0A193 0 3 00000001
I FFF0B213 0 4 00000001
I 7FF0B293 0 5 00000000
I 8000A313 0 6 00000000
I 5A50C393 0 7 FFFFFA5E
I 0F006413 0 8 000000F0
I 7F03F493 0 9 00000250
I 00409513 0 10 FFFFFFB0
I 01C0D593 0 11 0000000F
I 40815613 0 12 FFFFFFF7
D 2 FFFFF7FB
D 12 FFFFFFF7
T reg_ops
I FFF00693 0 13 FFFFFFFF
I 0016D693 0 13 7FFFFFFF
I 00468733 0 14 80000000
I 404707B3 0 15 7FFFFFFF
I 00F09833 0 16 80000000
I 40F858B3 0 17 FFFFFFFF
I 00A8D933 0 18 0000FFFF
I 0128A9B3 0 19 00000001
I 0138BA33 0 20 00000000
I 00794AB3 0 21 FFFF05A1
I 008AEB33 0 22 FFFF05F1
I 012B7BB3 0 23 000005F1
D 15 7FFFFFFF
D 23 000005F1
T lui
I DEADBC37 0 24 DEADB000
I 7EFC0C93 0 25 DEADB7EF
I 00001D37 0 26 00001000
D 24 DEADB000
T x0_dest
I 00708013 0 0 00000002
I 01AC0033 0 0 DEADC000
D 0 00000000
I 01A00DB3 0 27 00001000
I 40400E33 0 28 FFFFFFFF
T illegal
I 00000B8F 1 0 00000000
I 02108C33 1 0 00000000
I 00112CA3 1 0 00000000
D 23 000005F1
D 24 DEADB000
D 25 DEADB7EF
I 00100E93 0 29 00000001
D 29 00000001

/* list.f */
src/core_pkg.sv
src/exec_if.sv
src/instr_decoder.sv
src/register_file.sv
src/alu.sv
src/alu_core_top.sv
tests/alu_core_sva.sv
tests/alu_core_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = alu_core_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

# the run counts as passed only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/alu_core_tb.sv */
`default_nettype none

module alu_core_tb import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    CLK_PERIOD   = 100;
    localparam int    RESET_CYCLES = 10;
    localparam string GOLDEN_FILE  = "tests/alu_core_golden.txt";

    logic      clk;
    logic      rst_n;
    logic      instr_valid;
    instr_t    instr;
    reg_addr_t dbg_addr;
    logic      result_valid;
    word_t     result;
    reg_addr_t result_rd;
    logic      illegal;
    word_t     dbg_data;

    // one entry per golden step
    bit        step_is_instr[$];
    instr_t    step_instr[$];
    bit        step_ill[$];
    reg_addr_t step_addr[$];                    // rd or debug index
    word_t     step_val[$];
    int        step_test[$];

    string     test_name[$];
    int        test_errors[$];
    int        cur_test;
    int        error_count;
    int        tests_failed;
    bit        steps_ready;

    alu_core_top alu_core_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .dbg_addr     (dbg_addr),
        .result_valid (result_valid),
        .result       (result),
        .result_rd    (result_rd),
        .illegal      (illegal),
        .dbg_data     (dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic count_error();
        error_count++;
        test_errors[cur_test]++;
    endtask

    task automatic check_result(input reg_addr_t exp_rd, input word_t exp_val);
        if (result_rd !== exp_rd || result !== exp_val) begin
            $display("** Error at %0d ns: result x%0d = %08h, expected x%0d = %08h",
                     $time, result_rd, result, exp_rd, exp_val);
            count_error();
        end
    endtask

    task automatic check_reg(input reg_addr_t addr, input word_t exp_val);
        if (dbg_data !== exp_val) begin
            $display("** Error at %0d ns: debug read of x%0d = %08h, expected %08h",
                     $time, addr, dbg_data, exp_val);
            count_error();
        end
    endtask

    task automatic check_flags(input bit exp_valid, input bit exp_illegal);
        if (result_valid !== exp_valid) begin
            $display("result_valid was %b at %0d ns where %b was expected",
                     result_valid, $time, exp_valid);
            count_error();
        end
        if (illegal !== exp_illegal) begin
            $display("illegal flag was %b at %0d ns where %b was expected",
                     illegal, $time, exp_illegal);
            count_error();
        end
    endtask

    task automatic check_instr_report(input int idx);
        cur_test = step_test[idx];
        check_flags(!step_ill[idx], step_ill[idx]);
        if (!step_ill[idx] && result_valid === 1'b1) begin
            check_result(step_addr[idx], step_val[idx]);
        end
    endtask

    task automatic finish_test(input int t);
        if (test_errors[t] == 0) begin
            $display("test %0d %s: ok", t + 1, test_name[t]);
        end else begin
            $display("test %0d %s: %0d errors", t + 1, test_name[t], test_errors[t]);
            tests_failed++;
        end
    endtask

    task automatic load_golden(output bit ok);
        int     fd;
        int     n;
        int     ill;
        int     addr;
        string  tag;
        string  rest;
        string  name;
        instr_t ins;
        word_t  val;
        ok = 1'b0;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (ok && $fscanf(fd, "%s", tag) == 1) begin
                ins = '0;
                ill = 0;
                if (tag.getc(0) == "#") begin
                    n = $fgets(rest, fd);       // comment line
                end else if (tag == "T") begin
                    n = $fscanf(fd, "%s", name);
                    ok = (n == 1);
                    test_name.push_back(name);
                    test_errors.push_back(0);
                end else if (tag == "I" && test_name.size() > 0) begin
                    n = $fscanf(fd, "%h %d %d %h", ins, ill, addr, val);
                    ok = (n == 4);
                end else if (tag == "D" && test_name.size() > 0) begin
                    n = $fscanf(fd, "%d %h", addr, val);
                    ok = (n == 2);
                end else begin
                    ok = 1'b0;
                end
                if (ok && (tag == "I" || tag == "D")) begin
                    step_is_instr.push_back(tag == "I");
                    step_instr.push_back(ins);
                    step_ill.push_back(ill != 0);
                    step_addr.push_back(reg_addr_t'(addr));
                    step_val.push_back(val);
                    step_test.push_back(test_name.size() - 1);
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin : watchdog
        wait (steps_ready);
        #(CLK_PERIOD * (4 * step_is_instr.size() + RESET_CYCLES));
        abort_run("watchdog timeout, the golden steps did not complete in time");
    end

    initial begin
        bit load_ok;
        bit pending;
        int prev;
        instr_valid = 1'b0;
        instr       = '0;
        dbg_addr    = '0;
        rst_n       = 1'b0;
        pending     = 1'b0;
        prev        = 0;
        load_golden(load_ok);
        if (!load_ok) begin
            abort_run("golden file is missing or has a malformed line");
        end else begin
            steps_ready = 1'b1;
            repeat (RESET_CYCLES) @(posedge clk);
            rst_n <= 1'b1;
            for (int i = 0; i < step_is_instr.size(); i++) begin
                @(posedge clk);
                instr_valid <= step_is_instr[i];
                if (step_is_instr[i]) begin
                    instr <= step_instr[i];
                end else begin
                    dbg_addr <= step_addr[i];
                end
                @(negedge clk);
                cur_test = step_test[i];
                if (pending) begin
                    check_instr_report(prev);
                end else begin
                    check_flags(1'b0, 1'b0);    // no pulse while idle
                end
                if (i > 0 && step_test[i] != step_test[i - 1]) begin
                    finish_test(step_test[i - 1]);
                end
                if (!step_is_instr[i]) begin
                    cur_test = step_test[i];
                    check_reg(step_addr[i], step_val[i]);
                end
                pending = step_is_instr[i];
                prev    = i;
            end
            @(posedge clk);
            instr_valid <= 1'b0;
            @(negedge clk);
            if (pending) begin
                check_instr_report(prev);
            end
            if (step_test.size() > 0) begin
                finish_test(step_test[step_test.size() - 1]);
            end
            $display("%0d tests ok, %0d failed, %0d errors",
                     test_name.size() - tests_failed, tests_failed, error_count);
            if (tests_failed == 0 && error_count == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tests/alu_core_sva.sv */
`default_nettype none

module alu_core_sva import core_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      instr_valid,
    input logic      result_valid,
    input logic      illegal,
    input reg_addr_t dbg_addr,
    input word_t     dbg_data
);

    timeunit 1ns;
    timeprecision 1ps;

    report_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(result_valid && illegal))
        else $error("result_valid and illegal high in the same cycle");

    // report pulse follows a strobe by exactly one cycle
    report_after_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        (result_valid || illegal) |-> $past(instr_valid))
        else $error("report pulse without an instruction strobe one cycle earlier");

    dbg_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (dbg_addr == '0) |-> (dbg_data == '0))
        else $error("debug read of x0 returned %08h", dbg_data);

endmodule

bind alu_core_top alu_core_sva alu_core_sva_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .result_valid (result_valid),
    .illegal      (illegal),
    .dbg_addr     (dbg_addr),
    .dbg_data     (dbg_data)
);

`default_nettype wire

/* src/alu_core_top.sv */
`default_nettype none

module alu_core_top import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      instr_valid,
    input  instr_t    instr,
    input  reg_addr_t dbg_addr,
    output logic      result_valid,
    output word_t     result,
    output reg_addr_t result_rd,
    output logic      illegal,
    output word_t     dbg_data
);

    exec_if dec_bus ();

    logic  illegal_instr;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_b;
    word_t alu_y;

    instr_decoder u_decoder (
        .instr_valid   (instr_valid),
        .instr         (instr),
        .dec           (dec_bus.ctrl),
        .illegal_instr (illegal_instr)
    );

    register_file u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_addr1 (dec_bus.rs1),
        .rd_addr2 (dec_bus.rs2),
        .dbg_addr (dbg_addr),
        .wr_en    (dec_bus.wr_en),
        .wr_addr  (dec_bus.rd),
        .wr_data  (alu_y),                      // writeback same cycle
        .rd_data1 (rs1_data),
        .rd_data2 (rs2_data),
        .dbg_data (dbg_data)
    );

    assign alu_b = dec_bus.use_imm ? dec_bus.imm : rs2_data;

    alu u_alu (
        .op (dec_bus.op),
        .a  (rs1_data),
        .b  (alu_b),
        .y  (alu_y)
    );

    // report lags the writeback by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            illegal      <= 1'b0;
            result       <= '0;
            result_rd    <= '0;
        end else begin
            result_valid <= dec_bus.wr_en;
            illegal      <= instr_valid && illegal_instr;
            if (dec_bus.wr_en) begin
                result    <= alu_y;
                result_rd <= dec_bus.rd;       // x0 still reported
            end
        end
    end

endmodule

`default_nettype wire

/* src/alu.sv */
`default_nettype none

module alu import core_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];                      // rv32 shift range

    always_comb begin
        case (op)
            ALU_ADD: begin
                y = a + b;                      // wraps on overflow
            end
            ALU_SUB: begin
                y = a - b;
            end
            ALU_SLL: begin
                y = a << shamt;
            end
            ALU_SLT: begin
                y = word_t'($signed(a) < $signed(b));
            end
            ALU_SLTU: begin
                y = word_t'(a < b);
            end
            ALU_XOR: begin
                y = a ^ b;
            end
            ALU_SRL: begin
                y = a >> shamt;
            end
            ALU_SRA: begin
                y = word_t'($signed(a) >>> shamt);   // sign fill
            end
            ALU_OR: begin
                y = a | b;
            end
            ALU_AND: begin
                y = a & b;
            end
            ALU_PASS_B: begin
                y = b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/register_file.sv */
`default_nettype none

module register_file import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rd_addr1,
    input  reg_addr_t rd_addr2,
    input  reg_addr_t dbg_addr,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    output word_t     rd_data1,
    output word_t     rd_data2,
    output word_t     dbg_data
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];   // operand a
    assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];   // operand b
    assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

endmodule

`default_nettype wire

/* src/instr_decoder.sv */
`default_nettype none

module instr_decoder import core_pkg::*; (
    input  logic   instr_valid,
    input  instr_t instr,
    exec_if.ctrl   dec,
    output logic   illegal_instr
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       f7_ok;
    logic       legal;
    word_t      imm_i;
    word_t      imm_u;

    function automatic alu_op_e f3_to_op(input logic [2:0] f3, input logic use_alt);
        alu_op_e res;
        case (f3)
            F3_ADD_SUB: res = use_alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     res = ALU_SLL;
            F3_SLT:     res = ALU_SLT;
            F3_SLTU:    res = ALU_SLTU;
            F3_XOR:     res = ALU_XOR;
            F3_SRL_SRA: res = use_alt ? ALU_SRA : ALU_SRL;
            F3_OR:      res = ALU_OR;
            default:    res = ALU_AND;
        endcase
        return res;
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign alt   = funct7[F7_ALT_BIT];
    assign f7_ok = (funct7 & ~F7_ALT) == '0;    // only the marker bit may be set

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    assign dec.rd  = instr[11:7];
    assign dec.rs1 = instr[19:15];
    assign dec.rs2 = instr[24:20];
    assign dec.imm = (opcode == OPC_LUI) ? imm_u : imm_i;

    always_comb begin
        legal       = 1'b1;
        dec.op      = ALU_ADD;
        dec.use_imm = 1'b0;
        case (opcode)
            OPC_OP: begin
                dec.op = f3_to_op(funct3, alt);
                legal  = f7_ok && (!alt || funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA);
            end
            OPC_OP_IMM: begin
                dec.use_imm = 1'b1;
                // addi has no sub form so imm[10] is plain data
                dec.op = f3_to_op(funct3, funct3 == F3_SRL_SRA && alt);
                if (funct3 == F3_SLL) begin
                    legal = f7_ok && !alt;
                end else if (funct3 == F3_SRL_SRA) begin
                    legal = f7_ok;
                end
            end
            OPC_LUI: begin
                dec.op      = ALU_PASS_B;
                dec.use_imm = 1'b1;
            end
            default: begin
                legal = 1'b0;                   // unsupported opcode
            end
        endcase
    end

    assign illegal_instr = !legal;
    assign dec.wr_en     = instr_valid && legal;

endmodule

`default_nettype wire

/* src/exec_if.sv */
`default_nettype none

interface exec_if import core_pkg::*; ();

    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    alu_op_e   op;
    logic      use_imm;                     // b operand from imm
    logic      wr_en;

    modport ctrl (
        output rs1,
        output rs2,
        output rd,
        output imm,
        output op,
        output use_imm,
        output wr_en
    );

    modport dp (
        input rs1,
        input rs2,
        input rd,
        input imm,
        input op,
        input use_imm,
        input wr_en
    );

endinterface

`default_nettype wire

/* src/core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] instr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B                              // lui
    } alu_op_e;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 bit that picks sub / sra
    localparam int unsigned F7_ALT_BIT = 5;
    localparam logic [6:0]  F7_ALT     = 7'b1 << F7_ALT_BIT;

endpackage

`default_nettype wire
